// ==== fb_settings.svh ====
`ifndef FB_SETTINGS_SVH
`define FB_SETTINGS_SVH

// active area, pixels per line and lines per frame
`define FB_H_ACTIVE 4
`define FB_V_ACTIVE 4

// totals incl blanking
`define FB_H_TOTAL 8   // clocks per line
`define FB_V_TOTAL 6   // lines per frame

// sync pulses sit at the start of blanking, active high
`define FB_H_SYNC 2    // clocks
`define FB_V_SYNC 1    // lines

// words in one stored frame
`define FB_FRAME_WORDS (`FB_H_ACTIVE * `FB_V_ACTIVE)

// uart oversampling, clocks per bit
`define FB_UART_DIV 8

// entries in each fifo
`define FB_FIFO_DEPTH 4

`endif

// ==== fb_pkg.sv ====
`default_nettype none
`include "fb_settings.svh"

package fb_pkg;

  typedef logic [7:0] byte_t;    // one uart byte

  // byte k of a group of four lands in bits 8k+7:8k
  // so the first byte received is the lsb
  typedef logic [31:0] pixel_t;

  // one address per stored word
  typedef logic [$clog2(`FB_FRAME_WORDS)-1:0] addr_t;

  // byte as handed over by the receiver
  typedef struct packed {
    byte_t data;       // shifted-in payload
    logic  frame_err;  // stop bit sampled low
  } rx_byte_t;

endpackage

`default_nettype wire

// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

  // timing strobes, all active high
  typedef struct packed {
    logic hsync;  // line sync
    logic vsync;  // frame sync
    logic de;     // active pixel
  } sync_t;

  // what leaves the chip each clock
  typedef struct packed {
    sync_t          sync;   // strobes
    fb_pkg::pixel_t pixel;  // zero outside de
  } video_t;

endpackage

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fb_settings.svh"

module uart_rx (
  input  wire              sys_clk,   // system clock
  input  wire              rst_n,     // sync reset, active low
  input  wire              rx,        // serial line, idles high
  output fb_pkg::rx_byte_t rx_byte,   // data + framing flag
  output logic             rx_valid   // one clock per stop bit
);

  localparam int DIV = `FB_UART_DIV;
  localparam int CW  = $clog2(DIV);

  typedef enum logic [2:0] {IDLE, START, DATA, STOP, BREAK} state_t;

  state_t        state;
  logic          rx_m;      // first sync stage
  logic          rx_s;      // synced line
  logic [CW-1:0] clk_cnt;   // clocks within current bit
  logic [2:0]    bit_idx;   // data bit being sampled
  logic [7:0]    shift_q;   // lsb arrives first
  logic          half_bit;
  logic          bit_end;

  assign half_bit = (clk_cnt == CW'(DIV/2 - 1));  // middle of start bit
  assign bit_end  = (clk_cnt == CW'(DIV - 1));    // one full bit later

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      rx_m     <= 1'b1;  // line idles high
      rx_s     <= 1'b1;
      state    <= IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_m     <= rx;
      rx_s     <= rx_m;
      rx_valid <= 1'b0;               // pulse by default off
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        IDLE: begin
          clk_cnt <= '0;
          if (!rx_s) state <= START;  // falling line = start bit
        end
        START: if (half_bit) begin
          clk_cnt <= '0;
          bit_idx <= '0;
          state   <= rx_s ? IDLE : DATA;  // glitch, back to idle
        end
        DATA: if (bit_end) begin
          clk_cnt <= '0;
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) state <= STOP;
        end
        STOP: if (bit_end) begin
          rx_valid <= 1'b1;
          state    <= rx_s ? IDLE : BREAK;
        end
        // low stop bit, wait for the line to come back high
        BREAK: if (rx_s) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == DATA && bit_end) shift_q <= {rx_s, shift_q[7:1]};
    if (state == STOP && bit_end) begin
      rx_byte.data      <= shift_q;
      rx_byte.frame_err <= !rx_s;  // stop must be high
    end
  end

endmodule

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fb_settings.svh"

module sync_fifo #(
  parameter type payload_t = logic [7:0]  // entry type
) (
  input  wire                                   sys_clk,    // system clock
  input  wire                                   rst_n,      // sync reset, active low
  input  wire                                   push,       // write strobe
  input  wire payload_t                         push_data,  // entry to store
  input  wire                                   pop,        // advance head
  output payload_t                              pop_data,   // head, show-ahead
  output logic                                  not_empty,  // head valid
  output logic [$clog2(`FB_FIFO_DEPTH+1)-1:0]   count       // entries held
);

  localparam int DEPTH = `FB_FIFO_DEPTH;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];  // circular storage
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic          full;
  logic          do_push;
  logic          do_pop;

  assign full      = (count == CW'(DEPTH));
  assign not_empty = (count != '0);
  assign do_push   = push && !full;       // dropped when full
  assign do_pop    = pop && not_empty;    // ignored when empty
  assign pop_data  = mem[rd_ptr];         // head visible without a pop

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

`default_nettype wire

// ==== frame_buffer_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fb_settings.svh"

module frame_buffer_ctrl (
  input  wire                                 sys_clk,       // system clock
  input  wire                                 rst_n,         // sync reset, active low
  input  wire fb_pkg::rx_byte_t               rx_head,       // rx fifo head
  input  wire                                 rx_not_empty,  // head valid
  output logic                                rx_pop,        // take head
  output logic                                pix_push,      // word into pixel fifo
  output fb_pkg::pixel_t                      pix_word,      // word from store
  input  wire [$clog2(`FB_FIFO_DEPTH+1)-1:0]  pix_count,     // pixel fifo fill
  output logic                                read_enable,   // frame stored, replay on
  output logic                                frame_err      // sticky bad stop bit
);

  localparam int          WORDS = `FB_FRAME_WORDS;
  localparam fb_pkg::addr_t LAST = fb_pkg::addr_t'(WORDS - 1);

  fb_pkg::pixel_t mem [WORDS];  // on-chip frame store
  fb_pkg::addr_t  wr_addr;      // next word to fill
  fb_pkg::addr_t  rd_addr;      // next word to replay
  logic [1:0]     lane;         // byte slot in current word
  logic [23:0]    pack_q;       // lanes 0..2 waiting for lane 3
  logic           rd_inflight;  // store read issued last clock
  logic           good_byte;
  logic           wr_word;
  logic           rd_issue;

  assign rx_pop    = rx_not_empty && !read_enable;  // fill mode only
  assign good_byte = rx_pop && !rx_head.frame_err;
  assign wr_word   = good_byte && (lane == 2'd3);   // fourth byte completes word

  // count the read still in flight so the fifo never overfills
  assign rd_issue = read_enable &&
                    ((int'(pix_count) + int'(rd_inflight)) < `FB_FIFO_DEPTH);

  assign pix_push = rd_inflight;  // store data lands one clock after the read

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      wr_addr     <= '0;
      rd_addr     <= '0;
      lane        <= '0;
      rd_inflight <= 1'b0;
      read_enable <= 1'b0;
      frame_err   <= 1'b0;
    end else begin
      if (rx_pop && rx_head.frame_err) frame_err <= 1'b1;  // drop, remember it
      if (good_byte) lane <= lane + 1'b1;                  // wraps after 3
      if (wr_word) begin
        wr_addr <= wr_addr + 1'b1;
        if (wr_addr == LAST) read_enable <= 1'b1;  // held till reset
      end
      rd_inflight <= rd_issue;
      if (rd_issue) rd_addr <= (rd_addr == LAST) ? '0 : rd_addr + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (good_byte && !wr_word) pack_q[lane*8 +: 8] <= rx_head.data;  // lanes 0..2 only
    if (wr_word) mem[wr_addr] <= {rx_head.data, pack_q};  // lane 3 goes straight in
    if (rd_issue) pix_word <= mem[rd_addr];               // one clock read latency
  end

endmodule

`default_nettype wire

// ==== video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fb_settings.svh"

module video_timing (
  input  wire                 sys_clk,        // system clock
  input  wire                 rst_n,          // sync reset, active low
  input  wire                 read_enable,    // frame stored
  input  wire fb_pkg::pixel_t pix_data,       // pixel fifo head
  input  wire                 data_rd_valid,  // pixel fifo not empty
  output logic                pix_data_req,   // next clock is an active pixel
  output logic                pix_pop,        // take head
  output video_pkg::video_t   video,          // registered output
  output logic                underrun        // sticky, pixel due with no data
);

  localparam int HW = $clog2(`FB_H_TOTAL);
  localparam int VW = $clog2(`FB_V_TOTAL);

  logic [HW-1:0] h_cnt;    // active pixels first, then blanking
  logic [VW-1:0] v_cnt;    // active lines first
  logic          run_q;    // counters advancing
  logic          active;
  logic          hsync;
  logic          vsync;

  assign active = (h_cnt < HW'(`FB_H_ACTIVE)) && (v_cnt < VW'(`FB_V_ACTIVE));
  assign hsync  = (h_cnt >= HW'(`FB_H_ACTIVE)) &&
                  (h_cnt <  HW'(`FB_H_ACTIVE + `FB_H_SYNC));
  assign vsync  = (v_cnt >= VW'(`FB_V_ACTIVE)) &&
                  (v_cnt <  VW'(`FB_V_ACTIVE + `FB_V_SYNC));

  assign pix_data_req = run_q && active;  // counters point one clock ahead
  assign pix_pop      = read_enable && data_rd_valid && pix_data_req;

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      run_q    <= 1'b0;
      h_cnt    <= '0;
      v_cnt    <= '0;
      video.sync <= '0;
      underrun <= 1'b0;
    end else begin
      // start once the first prefetched word is waiting
      run_q <= read_enable && (run_q || data_rd_valid);
      if (!run_q) begin
        h_cnt <= '0;  // parked at frame start
        v_cnt <= '0;
      end else if (h_cnt == HW'(`FB_H_TOTAL - 1)) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == VW'(`FB_V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
      video.sync.hsync <= run_q && hsync;
      video.sync.vsync <= run_q && vsync;
      video.sync.de    <= pix_data_req;
      if (pix_data_req && !data_rd_valid) underrun <= 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    video.pixel <= pix_pop ? pix_data : '0;  // blank outside de or on underrun
  end

endmodule

`default_nettype wire

// ==== fb_test_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fb_settings.svh"

module fb_test_top (
  input  wire               sys_clk,    // system clock
  input  wire               rst_n,      // sync reset, active low
  input  wire               uart_rx_d,  // uart receive line
  output video_pkg::video_t video,      // sync + pixel
  output logic [3:0]        led         // {filled, framing err, underrun, 0}
);

  fb_pkg::rx_byte_t rx_byte;       // from receiver
  logic             rx_valid;
  fb_pkg::rx_byte_t rx_head;       // rx fifo head
  logic             rx_not_empty;
  logic             rx_pop;
  logic             pix_push;      // store read data valid
  fb_pkg::pixel_t   pix_word;
  fb_pkg::pixel_t   pix_data;      // pixel fifo head
  logic             data_rd_valid; // pixel fifo not empty
  logic             pix_pop;
  logic             read_enable;   // frame stored, replay running
  logic             frame_err;     // sticky
  logic             underrun;      // sticky
  logic [$clog2(`FB_FIFO_DEPTH+1)-1:0] pix_count;

  // same shape as the reference, minus pll lock
  assign led = {read_enable, frame_err, underrun, 1'b0};

  uart_rx u_uart_rx (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .rx       (uart_rx_d),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  sync_fifo #(.payload_t(fb_pkg::rx_byte_t)) u_rx_fifo (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .push      (rx_valid),  // every byte, good or bad
    .push_data (rx_byte),
    .pop       (rx_pop),
    .pop_data  (rx_head),
    .not_empty (rx_not_empty),
    .count     ()           // fill level not needed here
  );

  frame_buffer_ctrl u_fb_ctrl (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .rx_head      (rx_head),
    .rx_not_empty (rx_not_empty),
    .rx_pop       (rx_pop),
    .pix_push     (pix_push),
    .pix_word     (pix_word),
    .pix_count    (pix_count),
    .read_enable  (read_enable),
    .frame_err    (frame_err)
  );

  sync_fifo #(.payload_t(fb_pkg::pixel_t)) u_pix_fifo (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .push      (pix_push),
    .push_data (pix_word),
    .pop       (pix_pop),   // rd_en of the reference
    .pop_data  (pix_data),
    .not_empty (data_rd_valid),
    .count     (pix_count)  // throttles prefetch
  );

  video_timing u_video_timing (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .read_enable   (read_enable),
    .pix_data      (pix_data),
    .data_rd_valid (data_rd_valid),
    .pix_data_req  (),             // lookahead, folded into pix_pop
    .pix_pop       (pix_pop),
    .video         (video),
    .underrun      (underrun)
  );

endmodule

`default_nettype wire

// ==== tb_fb_test.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fb_settings.svh"

module tb_fb_test;

  localparam int DIV     = `FB_UART_DIV;
  localparam int WORDS   = `FB_FRAME_WORDS;
  localparam int ENTRIES = 66;                       // 64 good bytes + 2 bad
  localparam int BAD_A   = 9;                        // entries with a low stop bit
  localparam int BAD_B   = 37;
  localparam int FRAME   = `FB_H_TOTAL * `FB_V_TOTAL; // clocks per frame
  localparam int PHASE   = ENTRIES * 10 * DIV + 3 * FRAME + 200;
  localparam int LIMIT   = 2 * PHASE;                // two fills, each with 3 frames
  localparam logic [127:0] CORNERS = 128'h00ff55aa_01807ffe_0ff03cc3_a55a11ee;

  typedef struct packed {
    fb_pkg::byte_t data;      // payload bits
    logic          bad_stop;  // stop bit driven low
  } stim_t;

  logic              sys_clk;
  logic              rst_n;
  logic              uart_rx_d;
  video_pkg::video_t video;
  logic [3:0]        led;

  stim_t          stim_tbl [ENTRIES];
  fb_pkg::pixel_t exp_frame [WORDS];  // good bytes packed lsb first
  logic           last_started;       // last good byte on the line
  logic           prev_de;
  logic           prev_hs;
  logic           prev_vs;
  int             cycles = 0;
  int             pix_idx;
  int             line_de;
  int             frame_de;
  int             de_total;
  int             hs_cnt;
  int             vs_rises;

  fb_test_top dut (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .uart_rx_d (uart_rx_d),
    .video     (video),
    .led       (led)
  );

  initial begin
    sys_clk = 1'b0;
    forever #10 sys_clk = ~sys_clk;  // 20 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) abort_run("timeout: fill and replay did not complete in time");
  end

  task automatic build_table();
    int g;
    g = 0;
    for (int i = 0; i < ENTRIES; i++) begin
      if (i == BAD_A || i == BAD_B) begin
        stim_tbl[i].data     = 8'(i) ^ 8'hc0;  // never stored
        stim_tbl[i].bad_stop = 1'b1;
      end else begin
        stim_tbl[i].data     = (g < 16) ? CORNERS[8*g +: 8] : 8'($urandom);
        stim_tbl[i].bad_stop = 1'b0;
        exp_frame[g/4][8*(g%4) +: 8] = stim_tbl[i].data;  // byte k into lane k
        g++;
      end
    end
  endtask

  task automatic drive_bit(input logic b);
    @(negedge sys_clk);
    uart_rx_d <= b;
    repeat (DIV - 1) @(negedge sys_clk);  // hold for one bit time
  endtask

  task automatic send_byte(input stim_t s);
    drive_bit(1'b0);                              // start
    for (int k = 0; k < 8; k++) drive_bit(s.data[k]);  // lsb first
    drive_bit(!s.bad_stop);
    if (s.bad_stop) drive_bit(1'b1);              // line back high before next start
  endtask

  task automatic wait_led(input int b);
    while (led[b] !== 1'b1) @(negedge sys_clk);  // bounded by the cycle limit
  endtask

  task automatic apply_reset();
    @(negedge sys_clk);
    rst_n        <= 1'b0;
    last_started <= 1'b0;
    repeat (2) @(negedge sys_clk);
    assert (led == 4'h0)
      else abort_run($sformatf("error: led got %h expected %h in reset", led, 4'h0));
    assert (video.sync.de == 1'b0)
      else abort_run($sformatf("error: video.sync.de got %h expected %h", video.sync.de, 1'b0));
    rst_n <= 1'b1;
  endtask

  task automatic fill_frame();
    for (int i = 0; i < ENTRIES; i++) begin
      if (i == ENTRIES - 1) last_started <= 1'b1;  // table ends on a good byte
      if (i == BAD_A) begin
        assert (led[2] == 1'b0)
          else abort_run($sformatf("error: led[2] got %h expected %h", led[2], 1'b0));
      end
      send_byte(stim_tbl[i]);
      if (stim_tbl[i].bad_stop) wait_led(2);  // framing error latched
    end
    wait_led(3);  // frame stored, replay on
  endtask

  task automatic check_replay();
    while (vs_rises < 3) @(negedge sys_clk);
    assert (de_total == 3 * WORDS)
      else abort_run($sformatf("error: de count got %h expected %h", de_total, 3 * WORDS));
    assert (led[1] == 1'b0)
      else abort_run($sformatf("error: led[1] got %h expected %h", led[1], 1'b0));
  endtask

  // outputs sampled mid-cycle, counters updated nonblocking
  always @(negedge sys_clk) begin
    prev_de <= video.sync.de;
    prev_hs <= video.sync.hsync;
    prev_vs <= video.sync.vsync;
    if (!rst_n) begin
      pix_idx  <= 0;
      line_de  <= 0;
      frame_de <= 0;
      de_total <= 0;
      hs_cnt   <= 0;
      vs_rises <= 0;
    end else begin
      if (!last_started) begin
        assert (video.sync == '0)
          else abort_run($sformatf("error: video.sync got %h expected %h", video.sync, 3'h0));
        assert (led[3] == 1'b0)
          else abort_run($sformatf("error: led[3] got %h expected %h", led[3], 1'b0));
      end
      assert (led[1] == 1'b0)
        else abort_run($sformatf("error: led[1] got %h expected %h", led[1], 1'b0));
      if (video.sync.de) begin
        assert (video.pixel == exp_frame[pix_idx])
          else abort_run($sformatf("error: video.pixel got %h expected %h",
                                   video.pixel, exp_frame[pix_idx]));
        pix_idx  <= (pix_idx == WORDS - 1) ? 0 : pix_idx + 1;  // frame wraps
        line_de  <= line_de + 1;
        frame_de <= frame_de + 1;
        de_total <= de_total + 1;
      end
      if (prev_de && !video.sync.de) begin  // end of an active line
        assert (line_de == `FB_H_ACTIVE)
          else abort_run($sformatf("error: de per line got %h expected %h",
                                   line_de, `FB_H_ACTIVE));
        line_de <= 0;
      end
      if (video.sync.hsync && !prev_hs) hs_cnt <= hs_cnt + 1;
      if (video.sync.vsync && !prev_vs) begin
        if (vs_rises != 0) begin  // first frame starts mid-way between vsyncs
          assert (hs_cnt == `FB_V_TOTAL)
            else abort_run($sformatf("error: hsync per frame got %h expected %h",
                                     hs_cnt, `FB_V_TOTAL));
        end
        assert (frame_de == WORDS)
          else abort_run($sformatf("error: de per frame got %h expected %h", frame_de, WORDS));
        hs_cnt   <= 0;
        frame_de <= 0;
        vs_rises <= vs_rises + 1;
      end
    end
  end

  initial begin
    rst_n        = 1'b0;
    uart_rx_d    = 1'b1;  // idle line
    last_started = 1'b0;
    void'($urandom(18));  // seeds this thread once
    build_table();
    apply_reset();
    fill_frame();
    check_replay();
    while (!video.sync.de) @(negedge sys_clk);  // into the fourth frame
    apply_reset();
    fill_frame();  // refill from the same table
    check_replay();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
fb_pkg.sv
video_pkg.sv
uart_rx.sv
sync_fifo.sv
frame_buffer_ctrl.sv
video_timing.sv
fb_test_top.sv
tb_fb_test.sv

// ==== Bender.yml ====
package:
  name: fb_test

export_include_dirs:
  - .

sources:
  - fb_pkg.sv
  - video_pkg.sv
  - uart_rx.sv
  - sync_fifo.sv
  - frame_buffer_ctrl.sv
  - video_timing.sv
  - fb_test_top.sv
  - target: test
    files:
      - tb_fb_test.sv
